// ==== src/vic_pkg.sv ====
package vic_pkg;

    typedef logic [6:0] raster_x_t;  // phi cycle within a line
    typedef logic [8:0] raster_y_t;  // line number
    typedef logic [5:0] reg_addr_t;  // adl
    typedef logic [7:0] reg_data_t;
    typedef logic [3:0] colour_t;    // palette index

    typedef struct packed {
        logic [1:0] red;
        logic [1:0] green;
        logic [1:0] blue;
    } rgb_t;

    typedef enum logic {
        chip_6567r8 = 1'b0,  // NTSC
        chip_6569   = 1'b1   // PAL
    } chip_t;

    typedef struct packed {
        logic phi;       // high in phases 2 and 3
        logic phi_rise;  // phase 2 strobe
        logic phi_end;   // phase 3 strobe, last sys cycle of phi
    } phase_t;

    typedef struct packed {
        logic      sel;    // ce low
        logic      write;  // rw low
        reg_addr_t addr;
        reg_data_t wdata;
    } cpu_bus_t;

    typedef struct packed {
        raster_x_t x;
        raster_y_t y;
    } raster_pos_t;

    localparam int unsigned rst_stretch_cycles = 16;
    localparam int unsigned rst_cnt_w = $clog2(rst_stretch_cycles + 1);
    typedef logic [rst_cnt_w-1:0] rst_cnt_t;

    localparam raster_x_t ntsc_line_cycles = 7'd65;
    localparam raster_y_t ntsc_lines       = 9'd263;
    localparam raster_x_t pal_line_cycles  = 7'd63;
    localparam raster_y_t pal_lines        = 9'd312;

    localparam raster_x_t hsync_start = 7'd55;  // in phi cycles
    localparam raster_x_t hsync_len   = 7'd5;
    localparam raster_y_t vsync_start = 9'd14;  // in lines
    localparam raster_y_t vsync_len   = 9'd3;

    localparam reg_addr_t reg_ctrl1    = 6'h11;
    localparam reg_addr_t reg_raster   = 6'h12;
    localparam reg_addr_t reg_irq_stat = 6'h19;
    localparam reg_addr_t reg_irq_en   = 6'h1a;
    localparam reg_addr_t reg_border   = 6'h20;

    // rr_gg_bb, rough 2 bit take on the usual 16 colours
    localparam rgb_t palette [16] = '{
        6'b00_00_00, 6'b11_11_11, 6'b10_00_00, 6'b01_11_11,  // black white red cyan
        6'b10_00_10, 6'b00_10_00, 6'b00_00_10, 6'b11_11_01,  // purple green blue yellow
        6'b10_01_00, 6'b01_01_00, 6'b11_01_01, 6'b01_01_01,  // orange brown lt red dk grey
        6'b10_10_10, 6'b01_11_01, 6'b01_01_11, 6'b11_11_10   // grey lt green lt blue lt grey
    };

endpackage

// ==== src/reset_stretch.sv ====
module reset_stretch import vic_pkg::*; (
    input  logic sys_clockb,
    input  logic ext_rst,
    output logic internal_rst
);

    // counts down from the stretch length once ext_rst is gone
    rst_cnt_t cnt;

    always_ff @(posedge sys_clockb) begin
        if (ext_rst) begin
            cnt <= rst_cnt_t'(rst_stretch_cycles);  // reload while held
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // high through ext_rst and until the count runs out
    assign internal_rst = ext_rst | (cnt != '0);

endmodule

// ==== src/phase_gen.sv ====
module phase_gen import vic_pkg::*; (
    input  logic   sys_clockb,
    input  logic   internal_rst,
    output phase_t phase,
    output logic   aec,
    output logic   ras,
    output logic   cas
);

    logic [1:0] cnt;      // phase 0..3 within one phi cycle
    logic [1:0] cnt_nxt;

    assign cnt_nxt = cnt + 2'd1;

    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            cnt <= 2'd0;
        end else begin
            cnt <= cnt_nxt;  // free running, 4 sys cycles per phi
        end
    end

    // dram strobes decoded from the phase, forced low in reset
    assign ras = ~internal_rst & (cnt == 2'd0);  // low in phases 1 to 3
    assign cas = ~internal_rst & (cnt != 2'd3);  // low in phase 3 only

    // counter sits at 0 in reset so these decode low there
    assign phase.phi      = cnt[1];           // phases 2 and 3
    assign phase.phi_rise = (cnt == 2'd2);
    assign phase.phi_end  = (cnt == 2'd3);

    assign aec = phase.phi;  // cpu owns the bus while phi is high

endmodule

// ==== src/raster_timing.sv ====
module raster_timing import vic_pkg::*; (
    input  logic        sys_clockb,
    input  logic        internal_rst,
    input  logic        chip_sel,     // strap, 1 = PAL
    input  phase_t      phase,
    input  colour_t     border,
    input  raster_y_t   compare,
    output raster_pos_t pos,
    output logic        raster_hit,
    output logic        csync,
    output rgb_t        rgb
);

    chip_t       chip;
    raster_x_t   line_len;
    raster_y_t   line_cnt;
    raster_pos_t pos_q;
    logic        hsync;
    logic        vsync;
    logic        sync;

    // strap follows the pin for as long as reset is held
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            chip <= chip_sel ? chip_6569 : chip_6567r8;
        end
    end

    always_comb begin
        if (chip == chip_6569) begin
            line_len = pal_line_cycles;
            line_cnt = pal_lines;
        end else begin
            line_len = ntsc_line_cycles;
            line_cnt = ntsc_lines;
        end
    end

    // beam position, one step per phi cycle
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            pos_q.x <= '0;
            pos_q.y <= '0;
        end else if (phase.phi_end) begin
            if (pos_q.x == line_len - 1'b1) begin
                pos_q.x <= '0;  // end of line
                if (pos_q.y == line_cnt - 1'b1) begin
                    pos_q.y <= '0;  // end of frame
                end else begin
                    pos_q.y <= pos_q.y + 1'b1;
                end
            end else begin
                pos_q.x <= pos_q.x + 1'b1;
            end
        end
    end

    assign pos = pos_q;

    assign hsync = (pos_q.x >= hsync_start) && (pos_q.x < hsync_start + hsync_len);
    assign vsync = (pos_q.y >= vsync_start) && (pos_q.y < vsync_start + vsync_len);
    assign sync  = hsync | vsync;

    // video pins one sys cycle behind pos
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            csync <= 1'b1;
            rgb   <= '0;
        end else begin
            csync <= ~sync;                     // active low, h and v merged
            rgb   <= sync ? '0 : palette[border];  // blank during sync
        end
    end

    // whole first phi cycle of the matching line
    assign raster_hit = (pos_q.x == '0) && (pos_q.y == compare);

endmodule

// ==== src/vic_regs.sv ====
module vic_regs import vic_pkg::*; (
    input  logic        sys_clockb,
    input  logic        internal_rst,
    input  phase_t      phase,
    input  cpu_bus_t    cpu_bus,
    input  raster_pos_t pos,
    input  logic        raster_hit,
    output colour_t     border,
    output raster_y_t   compare,
    output reg_data_t   rdata,
    output logic        drive_db,
    output logic        irq        // active low
);

    logic [6:0] ctrl1_q;     // ctrl1 bits 6:0, stored only
    colour_t    border_q;
    raster_y_t  compare_q;
    logic       irq_en_q;    // raster irq enable
    logic       flag_q;      // raster irq pending
    logic       wr;
    logic       flag_clr;
    logic       irq_active;

    // cpu write lands on the last sys cycle of phi
    assign wr       = phase.phi_end & cpu_bus.sel & cpu_bus.write;
    assign flag_clr = wr && (cpu_bus.addr == reg_irq_stat) && cpu_bus.wdata[0];

    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            ctrl1_q   <= '0;
            border_q  <= '0;
            compare_q <= '0;
            irq_en_q  <= 1'b0;
        end else if (wr) begin
            case (cpu_bus.addr)
                reg_ctrl1: begin
                    compare_q[8] <= cpu_bus.wdata[7];  // compare msb
                    ctrl1_q      <= cpu_bus.wdata[6:0];
                end
                reg_raster: compare_q[7:0] <= cpu_bus.wdata;
                reg_irq_en: irq_en_q       <= cpu_bus.wdata[0];
                reg_border: border_q       <= cpu_bus.wdata[3:0];
                default: ;  // status is write-1-to-clear, handled below
            endcase
        end
    end

    // a hit wins over a clear in the same cycle
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            flag_q <= 1'b0;
        end else if (raster_hit) begin
            flag_q <= 1'b1;
        end else if (flag_clr) begin
            flag_q <= 1'b0;
        end
    end

    assign irq_active = flag_q & irq_en_q;
    assign irq        = ~irq_active;

    // reads see the live beam line, not the compare value
    always_comb begin
        case (cpu_bus.addr)
            reg_ctrl1:    rdata = {pos.y[8], ctrl1_q};
            reg_raster:   rdata = pos.y[7:0];
            reg_irq_stat: rdata = {irq_active, 6'b111111, flag_q};
            reg_irq_en:   rdata = {7'h7f, irq_en_q};
            reg_border:   rdata = {4'hf, border_q};
            default:      rdata = 8'hff;  // unmapped
        endcase
    end

    assign drive_db = phase.phi & cpu_bus.sel & ~cpu_bus.write;  // cpu read window

    assign border  = border_q;
    assign compare = compare_q;

endmodule

// ==== src/vic_top.sv ====
module vic_top import vic_pkg::*; (
    input  logic            sys_clockb,
    input  logic            ext_rst,
    input  logic            chip_sel,   // 0 = NTSC, 1 = PAL
    input  logic [5:0]      adl,
    inout  tri   [11:0]     db,
    input  logic            ce,         // active low
    input  logic            rw,         // low = write
    output logic            cpu_reset,
    output logic            clk_phi,
    output logic            aec,
    output logic            ras,
    output logic            cas,
    output logic            csync,      // active low
    output logic            irq,        // active low
    output logic [1:0]      red,
    output logic [1:0]      green,
    output logic [1:0]      blue
);

    logic        internal_rst;
    phase_t      phase;
    cpu_bus_t    cpu_bus;
    raster_pos_t pos;
    logic        raster_hit;
    colour_t     border;
    raster_y_t   compare;
    reg_data_t   rdata;
    logic        drive_db;
    rgb_t        rgb;

    reset_stretch i_reset_stretch (
        .sys_clockb   (sys_clockb),
        .ext_rst      (ext_rst),
        .internal_rst (internal_rst)
    );

    phase_gen i_phase_gen (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .phase        (phase),
        .aec          (aec),
        .ras          (ras),
        .cas          (cas)
    );

    raster_timing i_raster_timing (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .chip_sel     (chip_sel),
        .phase        (phase),
        .border       (border),
        .compare      (compare),
        .pos          (pos),
        .raster_hit   (raster_hit),
        .csync        (csync),
        .rgb          (rgb)
    );

    // pins to bus struct, only the low byte of db is data
    assign cpu_bus.sel   = ~ce;
    assign cpu_bus.write = ~rw;
    assign cpu_bus.addr  = adl;
    assign cpu_bus.wdata = db[7:0];

    vic_regs i_vic_regs (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .phase        (phase),
        .cpu_bus      (cpu_bus),
        .pos          (pos),
        .raster_hit   (raster_hit),
        .border       (border),
        .compare      (compare),
        .rdata        (rdata),
        .drive_db     (drive_db),
        .irq          (irq)
    );

    assign cpu_reset = internal_rst;  // cpu held with the chip
    assign clk_phi   = phase.phi;
    assign red       = rgb.red;
    assign green     = rgb.green;
    assign blue      = rgb.blue;

    // upper nibble pulled high on reads, bus released otherwise
    assign db = drive_db ? {4'hf, rdata} : 12'bz;

endmodule

// ==== testbench/vic_sva.sv ====
module vic_sva (
    input logic sys_clockb,
    input logic cpu_reset,
    input logic irq,
    input logic drive_db,
    input logic clk_phi,
    input logic aec,
    input logic ras,
    input logic cas
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;  // polled by vic_tb

    // one reset edge in, regs are cleared
    reset_quiet: assert property (@(posedge sys_clockb)
        cpu_reset && $past(cpu_reset) |-> irq && !drive_db)
        else begin
            fail_cnt++;
            $error("irq low or db driven while cpu_reset is high");
        end

    // aec tracks phi, and phi flips every two sys cycles once out of reset
    aec_is_phi: assert property (@(posedge sys_clockb) disable iff (cpu_reset)
        aec == clk_phi && (clk_phi != $past(clk_phi, 2) || $past(cpu_reset, 2)))
        else begin
            fail_cnt++;
            $error("aec differs from clk_phi or clk_phi out of step");
        end

    cas_in_ras: assert property (@(posedge sys_clockb) disable iff (cpu_reset)
        !cas |-> !ras)  // cas only inside the ras window
        else begin
            fail_cnt++;
            $error("cas low while ras high");
        end

endmodule

bind vic_top vic_sva i_vic_sva (.*);

// ==== testbench/vic_tb.sv ====
module vic_tb import vic_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic        sys_clockb;
    logic        ext_rst;
    logic        chip_sel;
    logic [5:0]  adl;
    logic        ce;
    logic        rw;
    logic        db_oe;       // tb owns db during writes
    logic [7:0]  db_out;
    wire  [11:0] db;
    logic        cpu_reset, clk_phi, aec, ras, cas, csync, irq;
    logic [1:0]  red, green, blue;

    logic [31:0] rng;
    logic        m_pal;       // model copy of the strap
    raster_x_t   mx, px;      // model beam, and one cycle back
    raster_y_t   my, py;
    colour_t     m_border, pb;
    logic [6:0]  m_ctrl1;
    logic        m_irq_en;
    logic        m_flag;
    logic        cmp_valid;

    vic_top i_dut (.*);

    assign db = db_oe ? {4'h0, db_out} : 'z;

    initial begin
        sys_clockb = 1'b0;
        forever #5 sys_clockb = ~sys_clockb;
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int frame_len();  // sys cycles per frame
        return m_pal ? 4 * int'(pal_line_cycles) * int'(pal_lines)
                     : 4 * int'(ntsc_line_cycles) * int'(ntsc_lines);
    endfunction

    // {csync, rgb} expected for a beam position
    function automatic logic [6:0] ref_pixel(raster_x_t x, raster_y_t y, colour_t b);
        logic sync;
        sync = ((x >= hsync_start) && (x < hsync_start + hsync_len))
            || ((y >= vsync_start) && (y < vsync_start + vsync_len));
        return sync ? 7'd0 : {1'b1, palette[b]};
    endfunction

    function automatic reg_data_t ref_read(reg_addr_t a);
        case (a)
            reg_ctrl1:    return {my[8], m_ctrl1};
            reg_raster:   return my[7:0];
            reg_irq_stat: return {m_flag & m_irq_en, 6'h3f, m_flag};
            reg_irq_en:   return {7'h7f, m_irq_en};
            reg_border:   return {4'hf, m_border};
            default:      return 8'hff;
        endcase
    endfunction

    task automatic check_eq(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "stopping on mismatch");
        end
    endtask

    task automatic timeout_fail(string what);
        $display("timed out waiting for %s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    // returns on the falling sys edge inside phase 0
    task automatic phi_start();
        int n;
        n = 0;
        do begin
            @(negedge sys_clockb);
            n++;
        end while (clk_phi !== 1'b1 && n < 16);
        if (clk_phi !== 1'b1) timeout_fail("clk_phi to rise");
        while (clk_phi !== 1'b0 && n < 32) begin
            @(negedge sys_clockb);
            n++;
        end
        if (clk_phi !== 1'b0) timeout_fail("clk_phi to fall");
    endtask

    task automatic cpu_write(reg_addr_t a, reg_data_t d);
        phi_start();
        ce = 1'b0;
        rw = 1'b0;
        adl = a;
        db_out = d;
        db_oe = 1'b1;
        repeat (3) @(negedge sys_clockb);  // through phase 3
        @(posedge sys_clockb);             // phi_end edge, data taken here
        case (a)
            reg_ctrl1:    m_ctrl1 = d[6:0];
            reg_irq_stat: if (d[0]) m_flag = 1'b0;
            reg_irq_en:   m_irq_en = d[0];
            reg_border:   m_border = d[3:0];
            default: ;
        endcase
        @(negedge sys_clockb);
        ce = 1'b1;
        rw = 1'b1;
        db_oe = 1'b0;
    endtask

    task automatic cpu_read(reg_addr_t a);
        phi_start();
        ce = 1'b0;
        adl = a;
        repeat (2) @(negedge sys_clockb);  // phase 2, db driven
        check_eq(db, {4'hf, ref_read(a)}, $sformatf("read of reg %h", a));
        repeat (2) @(negedge sys_clockb);
        ce = 1'b1;
    endtask

    task automatic run_reset(logic pal);
        int n;
        @(negedge sys_clockb);
        chip_sel = pal;
        ext_rst = 1'b1;
        ce = 1'b0;  // read held through reset, db must stay released
        rw = 1'b1;
        adl = reg_border;
        repeat (8) begin
            @(negedge sys_clockb);
            check_eq(irq, 1'b1, "irq in reset");
            check_eq(db, 12'hzzz, "db in reset");
            check_eq({clk_phi, ras, cas}, 3'b000, "phi and dram strobes in reset");
            check_eq({csync, red, green, blue}, 7'b1_000000, "video pins in reset");
        end
        ext_rst = 1'b0;
        n = 0;
        while (cpu_reset !== 1'b0 && n < 64) begin  // stretch still running
            @(negedge sys_clockb);
            check_eq(irq, 1'b1, "irq in reset");
            check_eq(db, 12'hzzz, "db in reset");
            n++;
        end
        if (cpu_reset !== 1'b0) timeout_fail("cpu_reset to fall");
        check_eq(n, rst_stretch_cycles, "cpu_reset length after ext_rst");
        ce = 1'b1;
        for (int i = 0; i < 16; i++) begin
            check_eq(clk_phi, (i >> 1) & 1, "clk_phi after reset");  // 2 low, 2 high
            check_eq(ras, (i % 4) == 0, "ras after reset");         // high in phase 0
            check_eq(cas, (i % 4) != 3, "cas after reset");         // low in phase 3
            @(negedge sys_clockb);
        end
    endtask

    task automatic raster_reads();
        repeat (24) begin  // spread over about one frame
            repeat (xorshift32() % (frame_len() / 12)) @(negedge sys_clockb);
            cpu_read(reg_raster);
            cpu_read(reg_ctrl1);
        end
    endtask

    task automatic raster_irq();
        raster_y_t target;
        int        lines;
        int        n;
        lines = m_pal ? int'(pal_lines) : int'(ntsc_lines);
        target = raster_y_t'((my + 50 + xorshift32() % 100) % lines);  // well ahead of beam
        cpu_write(reg_raster, target[7:0]);
        cpu_write(reg_ctrl1, {target[8], m_ctrl1});
        cpu_write(reg_irq_stat, 8'h01);  // drop any stale flag
        cpu_write(reg_irq_en, 8'h01);
        n = 0;
        while (irq !== 1'b0 && n < frame_len() + 64) begin
            @(negedge sys_clockb);
            n++;
        end
        if (irq !== 1'b0) timeout_fail("the raster irq");
        check_eq(my, target, "model line at irq");
        m_flag = 1'b1;
        cpu_read(reg_irq_stat);
        cpu_write(reg_irq_stat, 8'h01);
        check_eq(irq, 1'b1, "irq after clear");
        cpu_read(reg_irq_stat);
        cpu_write(reg_irq_en, 8'h00);
        repeat (frame_len()) begin
            @(negedge sys_clockb);
            check_eq(irq, 1'b1, "irq while disabled");
        end
        m_flag = 1'b1;  // compare line passed again
        cpu_read(reg_irq_stat);
    endtask

    // model beam moves with falling phi, like pos in the DUT
    always @(negedge clk_phi) begin
        if (!cpu_reset) begin
            if (mx == (m_pal ? pal_line_cycles : ntsc_line_cycles) - 7'd1) begin
                mx = '0;
                my = (my == (m_pal ? pal_lines : ntsc_lines) - 9'd1) ? '0 : my + 9'd1;
            end else begin
                mx = mx + 7'd1;
            end
        end
    end

    // video pins against the position one sys cycle back
    always @(negedge sys_clockb) begin
        if (i_dut.i_vic_sva.fail_cnt != 0) begin
            $display("a bound assertion on the DUT pins failed");
            $display("Simulation FAILED");
            $fatal(1, "stopping on assertion failure");
        end else if (cpu_reset) begin
            mx = '0;
            my = '0;
            m_pal = chip_sel;
            m_ctrl1 = '0;
            m_irq_en = 1'b0;
            m_flag = 1'b0;
            m_border = '0;
            cmp_valid = 1'b0;
        end else begin
            if (cmp_valid) check_eq({csync, red, green, blue}, ref_pixel(px, py, pb), "csync/rgb");
            px = mx;
            py = my;
            pb = m_border;
            cmp_valid = 1'b1;
        end
    end

    initial begin
        logic [31:0] r;
        reg_addr_t   a;
        rng = 32'd94510;
        ext_rst = 1'b1;
        chip_sel = 1'b0;
        adl = '0;
        ce = 1'b1;
        rw = 1'b1;
        db_oe = 1'b0;
        db_out = '0;
        run_reset(1'b0);  // NTSC
        repeat (12) begin
            r = xorshift32();
            a = (r[1:0] == 2'd0) ? reg_border : (r[1:0] == 2'd1) ? reg_irq_en : reg_ctrl1;
            cpu_write(a, r[15:8]);
            cpu_read(a);
        end
        cpu_read(6'h00);
        cpu_read(6'h3f);
        repeat (8) begin  // flag not modelled yet, skip status
            a = reg_addr_t'(xorshift32());
            if (a != reg_irq_stat) cpu_read(a);
        end
        raster_reads();
        raster_irq();
        r = xorshift32();
        cpu_write(reg_border, {4'h0, r[3:0]});
        repeat (frame_len()) @(negedge sys_clockb);
        run_reset(1'b1);  // PAL
        raster_reads();
        r = xorshift32();
        cpu_write(reg_border, {4'h0, r[3:0]});
        repeat (frame_len()) @(negedge sys_clockb);
        if (i_dut.i_vic_sva.fail_cnt != 0) begin
            $display("a bound assertion on the DUT pins failed");
            $display("Simulation FAILED");
            $fatal(1, "stopping on assertion failure");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== vic_top.f ====
src/vic_pkg.sv
src/reset_stretch.sv
src/phase_gen.sv
src/raster_timing.sv
src/vic_regs.sv
src/vic_top.sv
testbench/vic_sva.sv
testbench/vic_tb.sv

// ==== Bender.yml ====
package:
  name: vic_top

sources:
  - files:
      - src/vic_pkg.sv
      - src/reset_stretch.sv
      - src/phase_gen.sv
      - src/raster_timing.sv
      - src/vic_regs.sv
      - src/vic_top.sv
  - target: test
    files:
      - testbench/vic_sva.sv
      - testbench/vic_tb.sv
